// File: Bender.yml
package:
  name: gt_chan_ctrl

sources:
  - rtl/gt_ctrl_pkg.sv
  - rtl/drp_req_if.sv
  - rtl/seq_ctrl_if.sv
  - rtl/drp_decode.sv
  - rtl/ctrl_regs.sv
  - rtl/status_sync.sv
  - rtl/reset_seq.sv
  - rtl/gt_chan_ctrl.sv
  - target: test
    files:
      - verif/tb_gt_chan_ctrl.sv

// File: list.f
rtl/gt_ctrl_pkg.sv
rtl/drp_req_if.sv
rtl/seq_ctrl_if.sv
rtl/drp_decode.sv
rtl/ctrl_regs.sv
rtl/status_sync.sv
rtl/reset_seq.sv
rtl/gt_chan_ctrl.sv
verif/tb_gt_chan_ctrl.sv

// File: rtl/ctrl_regs.sv
// Reads return the value held before the same request's write; drp_do is zero outside drp_rdy
`timescale 1ns/1ns

module ctrl_regs (
    input  logic drp_clk,
    input  logic gt_rx_reset_reg,
    drp_req_if.regs req,
    input  gt_ctrl_pkg::gt_status_t status,
    seq_ctrl_if.regs tx_ctrl,
    seq_ctrl_if.regs rx_ctrl,
    output logic [gt_ctrl_pkg::drp_data_w-1:0] drp_do,
    output logic drp_rdy,
    output logic gt_tx_pd,
    output logic gt_rx_pd,
    output logic gt_tx_qpll_sel,
    output logic gt_rx_qpll_sel,
    output logic gt_rxcdrhold,
    output logic gt_rxlpmen
);

    logic tx_reset_r;
    logic tx_pd_r;
    logic tx_qpll_sel_r;
    logic rx_reset_r;
    logic rx_pd_r;
    logic rx_qpll_sel_r;
    logic rx_cdrhold_r;
    logic rx_lpm_en_r;
    logic [gt_ctrl_pkg::drp_data_w-1:0] rdata;

    // Sequencers act on the fields directly
    assign tx_ctrl.reset_req = tx_reset_r;
    assign tx_ctrl.pd = tx_pd_r;
    assign tx_ctrl.qpll_sel = tx_qpll_sel_r;
    assign tx_ctrl.lpm_en = 1'b1;
    assign rx_ctrl.reset_req = rx_reset_r;
    assign rx_ctrl.pd = rx_pd_r;
    assign rx_ctrl.qpll_sel = rx_qpll_sel_r;
    assign rx_ctrl.lpm_en = rx_lpm_en_r;

    always_comb begin
        rdata = '0;
        case (req.sel)
            gt_ctrl_pkg::sel_tx_reset: begin
                rdata[0] = tx_reset_r;
                rdata[8] = tx_ctrl.reset_done;
                rdata[9] = status.tx_gt_done;
                rdata[11] = status.tx_prgdiv_done;
                rdata[12] = status.tx_usrclk_active;
            end
            gt_ctrl_pkg::sel_tx_cfg: rdata[1:0] = {tx_qpll_sel_r, tx_pd_r};
            gt_ctrl_pkg::sel_rx_reset: begin
                rdata[0] = rx_reset_r;
                rdata[8] = rx_ctrl.reset_done;
                rdata[9] = status.rx_gt_done;
                rdata[11] = status.rx_prgdiv_done;
                rdata[12] = status.rx_usrclk_active;
            end
            gt_ctrl_pkg::sel_rx_cfg: rdata[1:0] = {rx_qpll_sel_r, rx_pd_r};
            gt_ctrl_pkg::sel_rx_cdr: begin
                rdata[0] = rx_cdrhold_r;
                rdata[8] = status.rxcdrlock;
            end
            gt_ctrl_pkg::sel_rx_lpm: rdata[0] = rx_lpm_en_r;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge drp_clk or posedge gt_rx_reset_reg) begin
        if (gt_rx_reset_reg) begin
            drp_rdy <= 1'b0;
            drp_do <= '0;
            tx_reset_r <= 1'b0;
            tx_pd_r <= gt_ctrl_pkg::tx_pd_default;
            tx_qpll_sel_r <= gt_ctrl_pkg::tx_qpll_sel_default;
            rx_reset_r <= 1'b0;
            rx_pd_r <= gt_ctrl_pkg::rx_pd_default;
            rx_qpll_sel_r <= gt_ctrl_pkg::rx_qpll_sel_default;
            rx_cdrhold_r <= 1'b0;
            rx_lpm_en_r <= gt_ctrl_pkg::rx_lpm_en_default;
            gt_tx_pd <= gt_ctrl_pkg::tx_pd_default;
            gt_rx_pd <= gt_ctrl_pkg::rx_pd_default;
            gt_tx_qpll_sel <= gt_ctrl_pkg::tx_qpll_sel_default;
            gt_rx_qpll_sel <= gt_ctrl_pkg::rx_qpll_sel_default;
            gt_rxcdrhold <= 1'b0;
            gt_rxlpmen <= gt_ctrl_pkg::rx_lpm_en_default;
        end else begin
            drp_rdy <= req.valid;
            drp_do <= req.valid ? rdata : '0;
            if (req.valid && req.we) begin
                case (req.sel)
                    gt_ctrl_pkg::sel_tx_reset: tx_reset_r <= req.wdata[0];
                    gt_ctrl_pkg::sel_tx_cfg: {tx_qpll_sel_r, tx_pd_r} <= req.wdata[1:0];
                    gt_ctrl_pkg::sel_rx_reset: rx_reset_r <= req.wdata[0];
                    gt_ctrl_pkg::sel_rx_cfg: {rx_qpll_sel_r, rx_pd_r} <= req.wdata[1:0];
                    gt_ctrl_pkg::sel_rx_cdr: rx_cdrhold_r <= req.wdata[0];
                    gt_ctrl_pkg::sel_rx_lpm: rx_lpm_en_r <= req.wdata[0];
                    default: ;
                endcase
            end
            // Transceiver pins follow one cycle behind
            gt_tx_pd <= tx_pd_r;
            gt_rx_pd <= rx_pd_r;
            gt_tx_qpll_sel <= tx_qpll_sel_r;
            gt_rx_qpll_sel <= rx_qpll_sel_r;
            gt_rxcdrhold <= rx_cdrhold_r;
            gt_rxlpmen <= rx_lpm_en_r;
        end
    end

    // Every response traces back to a decoded request
    a_rdy_has_req: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        drp_rdy |-> $past(req.valid));

endmodule

// File: rtl/drp_decode.sv
// Adds one cycle to every DRP access; addresses outside the control space decode to sel_none
`timescale 1ns/1ns

module drp_decode (
    input  logic drp_clk,
    input  logic gt_rx_reset_reg,
    input  logic [gt_ctrl_pkg::drp_addr_w-1:0] drp_addr,
    input  logic [gt_ctrl_pkg::drp_data_w-1:0] drp_di,
    input  logic drp_en,
    input  logic drp_we,
    drp_req_if.decode req
);

    gt_ctrl_pkg::reg_sel_t sel_d;

    always_comb begin
        sel_d = gt_ctrl_pkg::sel_none;
        if (drp_addr[gt_ctrl_pkg::ctrl_space_bit]) begin
            case (drp_addr[gt_ctrl_pkg::ctrl_space_bit-1:0])
                gt_ctrl_pkg::tx_reset_addr: sel_d = gt_ctrl_pkg::sel_tx_reset;
                gt_ctrl_pkg::tx_cfg_addr: sel_d = gt_ctrl_pkg::sel_tx_cfg;
                gt_ctrl_pkg::rx_reset_addr: sel_d = gt_ctrl_pkg::sel_rx_reset;
                gt_ctrl_pkg::rx_cfg_addr: sel_d = gt_ctrl_pkg::sel_rx_cfg;
                gt_ctrl_pkg::rx_cdr_addr: sel_d = gt_ctrl_pkg::sel_rx_cdr;
                gt_ctrl_pkg::rx_lpm_addr: sel_d = gt_ctrl_pkg::sel_rx_lpm;
                default: sel_d = gt_ctrl_pkg::sel_none;
            endcase
        end
    end

    always_ff @(posedge drp_clk or posedge gt_rx_reset_reg) begin
        if (gt_rx_reset_reg) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= drp_en;
        end
    end

    // Request payload, qualified by valid
    always_ff @(posedge drp_clk) begin
        if (drp_en) begin
            req.we <= drp_we;
            req.sel <= sel_d;
            req.wdata <= drp_di;
        end
    end

endmodule

// File: rtl/drp_req_if.sv
// One decoded DRP request per valid strobe; there is no back-pressure
`timescale 1ns/1ns

interface drp_req_if;

    logic valid;
    logic we;
    gt_ctrl_pkg::reg_sel_t sel;
    logic [gt_ctrl_pkg::drp_data_w-1:0] wdata;

    modport decode (
        output valid, we, sel, wdata
    );

    modport regs (
        input valid, we, sel, wdata
    );

endinterface

// File: rtl/gt_chan_ctrl.sv
// DRP reads and writes complete two cycles after drp_en; status inputs may be asynchronous
`timescale 1ns/1ns

module gt_chan_ctrl (
    input  logic drp_clk,
    input  logic gt_rx_reset_reg,
    input  logic [gt_ctrl_pkg::drp_addr_w-1:0] drp_addr,
    input  logic [gt_ctrl_pkg::drp_data_w-1:0] drp_di,
    input  logic drp_en,
    input  logic drp_we,
    output logic [gt_ctrl_pkg::drp_data_w-1:0] drp_do,
    output logic drp_rdy,
    input  logic qpll0_lock,
    input  logic qpll1_lock,
    input  logic tx_usrclk_active,
    input  logic rx_usrclk_active,
    input  logic gt_tx_reset_done,
    input  logic gt_tx_prgdiv_reset_done,
    input  logic gt_rx_reset_done,
    input  logic gt_rx_prgdiv_reset_done,
    input  logic gt_rxcdrlock,
    output logic gt_tx_reset,
    output logic gt_tx_prgdiv_reset,
    output logic gt_tx_userrdy,
    output logic tx_reset_done,
    output logic gt_rx_reset,
    output logic gt_rx_prgdiv_reset,
    output logic gt_rx_userrdy,
    output logic rx_reset_done,
    output logic gt_tx_pd,
    output logic gt_rx_pd,
    output logic gt_tx_qpll_sel,
    output logic gt_rx_qpll_sel,
    output logic gt_rxcdrhold,
    output logic gt_rxlpmen
);

    drp_req_if req_if ();
    seq_ctrl_if tx_ctrl_if ();
    seq_ctrl_if rx_ctrl_if ();

    gt_ctrl_pkg::gt_status_t status;

    assign tx_reset_done = tx_ctrl_if.reset_done;
    assign rx_reset_done = rx_ctrl_if.reset_done;

    drp_decode u_drp_decode (
        .drp_clk, .gt_rx_reset_reg, .drp_addr, .drp_di, .drp_en, .drp_we,
        .req(req_if)
    );

    ctrl_regs u_ctrl_regs (
        .drp_clk, .gt_rx_reset_reg, .req(req_if), .status,
        .tx_ctrl(tx_ctrl_if), .rx_ctrl(rx_ctrl_if), .drp_do, .drp_rdy,
        .gt_tx_pd, .gt_rx_pd, .gt_tx_qpll_sel, .gt_rx_qpll_sel, .gt_rxcdrhold, .gt_rxlpmen
    );

    status_sync u_status_sync (
        .drp_clk, .gt_rx_reset_reg, .qpll0_lock, .qpll1_lock, .tx_usrclk_active,
        .rx_usrclk_active, .gt_tx_reset_done, .gt_tx_prgdiv_reset_done, .gt_rx_reset_done,
        .gt_rx_prgdiv_reset_done, .gt_rxcdrlock, .status
    );

    // TX has no CDR, its lock input is unused
    reset_seq #(.has_cdr_wait(1'b0)) u_tx_seq (
        .drp_clk, .gt_rx_reset_reg, .ctrl(tx_ctrl_if),
        .qpll0_lock(status.qpll0_lock), .qpll1_lock(status.qpll1_lock),
        .usrclk_active(status.tx_usrclk_active), .gt_done(status.tx_gt_done),
        .prgdiv_done(status.tx_prgdiv_done), .cdr_lock(1'b0),
        .gt_reset(gt_tx_reset), .prgdiv_reset(gt_tx_prgdiv_reset), .userrdy(gt_tx_userrdy)
    );

    reset_seq #(.has_cdr_wait(1'b1)) u_rx_seq (
        .drp_clk, .gt_rx_reset_reg, .ctrl(rx_ctrl_if),
        .qpll0_lock(status.qpll0_lock), .qpll1_lock(status.qpll1_lock),
        .usrclk_active(status.rx_usrclk_active), .gt_done(status.rx_gt_done),
        .prgdiv_done(status.rx_prgdiv_done), .cdr_lock(status.rxcdrlock),
        .gt_reset(gt_rx_reset), .prgdiv_reset(gt_rx_prgdiv_reset), .userrdy(gt_rx_userrdy)
    );

endmodule

// File: rtl/gt_ctrl_pkg.sv
// Control-space offsets are 16 bits wide and are decoded only when drp_addr[16] is set
package gt_ctrl_pkg;

    localparam int drp_addr_w = 17;
    localparam int drp_data_w = 16;
    localparam int ctrl_space_bit = 16;

    localparam int settle_cnt_w = 8;
    localparam int cdr_timeout_w = 20;

    // Control register offsets
    localparam logic [15:0] tx_reset_addr = 16'h0000;
    localparam logic [15:0] tx_cfg_addr = 16'h0001;
    localparam logic [15:0] rx_reset_addr = 16'h1000;
    localparam logic [15:0] rx_cfg_addr = 16'h1001;
    localparam logic [15:0] rx_cdr_addr = 16'h1020;
    localparam logic [15:0] rx_lpm_addr = 16'h1024;

    localparam logic tx_pd_default = 1'b0;
    localparam logic rx_pd_default = 1'b0;
    localparam logic tx_qpll_sel_default = 1'b0;
    localparam logic rx_qpll_sel_default = 1'b0;
    localparam logic rx_lpm_en_default = 1'b1;

    typedef enum logic [2:0] {
        sel_none,
        sel_tx_reset,
        sel_tx_cfg,
        sel_rx_reset,
        sel_rx_cfg,
        sel_rx_cdr,
        sel_rx_lpm
    } reg_sel_t;

    typedef enum logic [2:0] {
        st_reset,
        st_wait_lock,
        st_wait_cdr,
        st_wait_usrclk,
        st_done
    } reset_state_t;

    // Status as seen in drp_clk, after synchronization
    typedef struct packed {
        logic qpll0_lock;
        logic qpll1_lock;
        logic tx_usrclk_active;
        logic rx_usrclk_active;
        logic tx_gt_done;
        logic tx_prgdiv_done;
        logic rx_gt_done;
        logic rx_prgdiv_done;
        logic rxcdrlock;
    } gt_status_t;

endpackage

// File: rtl/reset_seq.sv
// Settle waits are 2**settle_cnt_w cycles; with has_cdr_wait the CDR wait ends on lock or timeout
`timescale 1ns/1ns

module reset_seq #(
    parameter bit has_cdr_wait = 1'b0
) (
    input  logic drp_clk,
    input  logic gt_rx_reset_reg,
    seq_ctrl_if.seq ctrl,
    input  logic qpll0_lock,
    input  logic qpll1_lock,
    input  logic usrclk_active,
    input  logic gt_done,
    input  logic prgdiv_done,
    input  logic cdr_lock,
    output logic gt_reset,
    output logic prgdiv_reset,
    output logic userrdy
);

    gt_ctrl_pkg::reset_state_t state;
    logic [gt_ctrl_pkg::settle_cnt_w-1:0] cnt;
    logic [gt_ctrl_pkg::cdr_timeout_w-1:0] cdr_cnt;
    logic qpll_sel_q;
    logic lpm_en_q;
    logic sel_lock;
    logic restart;

    assign sel_lock = ctrl.qpll_sel ? qpll1_lock : qpll0_lock;
    assign restart = ctrl.reset_req || ctrl.pd || !sel_lock ||
                     (ctrl.qpll_sel != qpll_sel_q) || (ctrl.lpm_en != lpm_en_q);

    always_ff @(posedge drp_clk or posedge gt_rx_reset_reg) begin
        if (gt_rx_reset_reg) begin
            state <= gt_ctrl_pkg::st_reset;
            cnt <= '0;
            cdr_cnt <= '0;
            qpll_sel_q <= has_cdr_wait ? gt_ctrl_pkg::rx_qpll_sel_default
                                       : gt_ctrl_pkg::tx_qpll_sel_default;
            lpm_en_q <= 1'b1;
            gt_reset <= 1'b1;
            prgdiv_reset <= 1'b1;
            userrdy <= 1'b0;
            ctrl.reset_done <= 1'b0;
        end else begin
            // Outputs trail the state by one cycle
            gt_reset <= (state == gt_ctrl_pkg::st_reset) || (state == gt_ctrl_pkg::st_wait_lock);
            prgdiv_reset <= !((state == gt_ctrl_pkg::st_wait_usrclk) ||
                              (state == gt_ctrl_pkg::st_done));
            userrdy <= state == gt_ctrl_pkg::st_done;
            ctrl.reset_done <= (state == gt_ctrl_pkg::st_done) && gt_done && prgdiv_done;
            qpll_sel_q <= ctrl.qpll_sel;
            lpm_en_q <= ctrl.lpm_en;
            cnt <= '0;
            cdr_cnt <= '0;

            case (state)
                gt_ctrl_pkg::st_reset: state <= gt_ctrl_pkg::st_wait_lock;
                gt_ctrl_pkg::st_wait_lock: begin
                    if (sel_lock && &cnt) begin
                        state <= has_cdr_wait ? gt_ctrl_pkg::st_wait_cdr
                                              : gt_ctrl_pkg::st_wait_usrclk;
                    end else if (sel_lock) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                gt_ctrl_pkg::st_wait_cdr: begin
                    // Give up on CDR lock after the timeout and carry on
                    cdr_cnt <= cdr_cnt + 1'b1;
                    if (cdr_lock) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (&cdr_cnt || (cdr_lock && &cnt)) begin
                        state <= gt_ctrl_pkg::st_wait_usrclk;
                        cnt <= '0;
                    end
                end
                gt_ctrl_pkg::st_wait_usrclk: begin
                    if (usrclk_active && &cnt) begin
                        state <= gt_ctrl_pkg::st_done;
                    end else if (usrclk_active) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                gt_ctrl_pkg::st_done: state <= gt_ctrl_pkg::st_done;
                default: state <= gt_ctrl_pkg::st_reset;
            endcase

            if (restart) begin
                state <= gt_ctrl_pkg::st_reset;
            end
        end
    end

    // The channel leaves reset a cycle before userrdy
    a_userrdy_after_reset: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        userrdy |-> !gt_reset && $past(!gt_reset));

endmodule

// File: rtl/seq_ctrl_if.sv
// Controls for one direction's reset sequencer; lpm_en is tied high on TX
`timescale 1ns/1ns

interface seq_ctrl_if;

    logic reset_req;
    logic pd;
    logic qpll_sel;
    logic lpm_en;
    logic reset_done;

    modport regs (
        output reset_req, pd, qpll_sel, lpm_en,
        input reset_done
    );

    modport seq (
        input reset_req, pd, qpll_sel, lpm_en,
        output reset_done
    );

endinterface

// File: rtl/status_sync.sv
// All status inputs are treated as level signals; pulses shorter than two drp_clk cycles may be lost
`timescale 1ns/1ns

module status_sync (
    input  logic drp_clk,
    input  logic gt_rx_reset_reg,
    input  logic qpll0_lock,
    input  logic qpll1_lock,
    input  logic tx_usrclk_active,
    input  logic rx_usrclk_active,
    input  logic gt_tx_reset_done,
    input  logic gt_tx_prgdiv_reset_done,
    input  logic gt_rx_reset_done,
    input  logic gt_rx_prgdiv_reset_done,
    input  logic gt_rxcdrlock,
    output gt_ctrl_pkg::gt_status_t status
);

    gt_ctrl_pkg::gt_status_t raw;
    gt_ctrl_pkg::gt_status_t meta;

    assign raw = '{
        qpll0_lock: qpll0_lock,
        qpll1_lock: qpll1_lock,
        tx_usrclk_active: tx_usrclk_active,
        rx_usrclk_active: rx_usrclk_active,
        tx_gt_done: gt_tx_reset_done,
        tx_prgdiv_done: gt_tx_prgdiv_reset_done,
        rx_gt_done: gt_rx_reset_done,
        rx_prgdiv_done: gt_rx_prgdiv_reset_done,
        rxcdrlock: gt_rxcdrlock
    };

    always_ff @(posedge drp_clk or posedge gt_rx_reset_reg) begin
        if (gt_rx_reset_reg) begin
            meta <= '0;
            status <= '0;
        end else begin
            meta <= raw;
            status <= meta;
        end
    end

endmodule

// File: verif/tb_gt_chan_ctrl.sv
// Settle waits are 256 cycles, so each bring-up wait allows 2000 cycles; CDR timeout is never reached
`timescale 1ns/1ns

module tb_gt_chan_ctrl;

    logic drp_clk;
    logic gt_rx_reset_reg;
    logic [16:0] drp_addr;
    logic [15:0] drp_di;
    logic drp_en;
    logic drp_we;
    logic [15:0] drp_do;
    logic drp_rdy;
    logic qpll0_lock;
    logic qpll1_lock;
    logic tx_usrclk_active;
    logic rx_usrclk_active;
    logic gt_tx_reset_done;
    logic gt_tx_prgdiv_reset_done;
    logic gt_rx_reset_done;
    logic gt_rx_prgdiv_reset_done;
    logic gt_rxcdrlock;
    logic gt_tx_reset;
    logic gt_tx_prgdiv_reset;
    logic gt_tx_userrdy;
    logic tx_reset_done;
    logic gt_rx_reset;
    logic gt_rx_prgdiv_reset;
    logic gt_rx_userrdy;
    logic rx_reset_done;
    logic gt_tx_pd;
    logic gt_rx_pd;
    logic gt_tx_qpll_sel;
    logic gt_rx_qpll_sel;
    logic gt_rxcdrhold;
    logic gt_rxlpmen;

    logic [31:0] lfsr_state;
    int pending;
    logic wr_tx_reset;
    logic wr_tx_cfg;
    logic wr_rx_cfg;
    logic wr_rx_cdr;
    logic wr_rx_lpm;

    gt_chan_ctrl u_gt_chan_ctrl (.*);

    initial begin
        drp_clk = 1'b0;
        forever #2 drp_clk = ~drp_clk;
    end

    function automatic logic [16:0] ctrl_addr(input logic [15:0] offset);
        return {1'b1, offset};
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic probe(input string name);
        if (name == "tx_reset_done") return tx_reset_done;
        else if (name == "gt_tx_userrdy") return gt_tx_userrdy;
        else if (name == "rx_reset_done") return rx_reset_done;
        else return gt_rx_userrdy;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    // Leaves drp_en high, so consecutive calls issue back-to-back requests
    task automatic write_reg(input logic [16:0] addr, input logic [15:0] data);
        @(posedge drp_clk);
        #1;
        drp_en = 1'b1;
        drp_we = 1'b1;
        drp_addr = addr;
        drp_di = data;
    endtask

    task automatic drain_requests();
        int cycles;
        @(posedge drp_clk);
        #1;
        drp_en = 1'b0;
        drp_we = 1'b0;
        cycles = 0;
        while (pending != 0 && cycles < 10) begin
            @(negedge drp_clk);
            cycles++;
        end
        if (pending != 0) begin
            abort_run("DRP requests still open without drp_rdy");
        end
    endtask

    task automatic read_reg(input string name, input logic [16:0] addr, input logic [15:0] exp);
        int cycles;
        drain_requests();
        @(posedge drp_clk);
        #1;
        drp_en = 1'b1;
        drp_we = 1'b0;
        drp_addr = addr;
        @(posedge drp_clk);
        #1;
        drp_en = 1'b0;
        cycles = 0;
        while (!drp_rdy && cycles < 10) begin
            @(negedge drp_clk);
            cycles++;
        end
        if (!drp_rdy) begin
            abort_run($sformatf("no drp_rdy for read %s", name));
        end else if (drp_do !== exp) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, drp_do));
        end
    endtask

    task automatic wait_signal(input string name, input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (probe(name) !== level && cycles < limit) begin
            @(negedge drp_clk);
            cycles++;
        end
        if (probe(name) !== level) begin
            abort_run($sformatf("timeout waiting for %s to become %b", name, level));
        end
    endtask

    always @(posedge drp_clk or posedge gt_rx_reset_reg) begin
        if (gt_rx_reset_reg) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(drp_en) - int'(drp_rdy);
        end
    end

    assign wr_tx_reset = drp_en && drp_we && drp_addr == ctrl_addr(gt_ctrl_pkg::tx_reset_addr);
    assign wr_tx_cfg = drp_en && drp_we && drp_addr == ctrl_addr(gt_ctrl_pkg::tx_cfg_addr);
    assign wr_rx_cfg = drp_en && drp_we && drp_addr == ctrl_addr(gt_ctrl_pkg::rx_cfg_addr);
    assign wr_rx_cdr = drp_en && drp_we && drp_addr == ctrl_addr(gt_ctrl_pkg::rx_cdr_addr);
    assign wr_rx_lpm = drp_en && drp_we && drp_addr == ctrl_addr(gt_ctrl_pkg::rx_lpm_addr);

    a_reset_values: assert property (@(posedge drp_clk) gt_rx_reset_reg || $fell(gt_rx_reset_reg)
        |-> gt_tx_reset && gt_rx_reset && gt_tx_prgdiv_reset && gt_rx_prgdiv_reset &&
            !gt_tx_userrdy && !gt_rx_userrdy && !tx_reset_done && !rx_reset_done && !drp_rdy &&
            gt_tx_pd == gt_ctrl_pkg::tx_pd_default && gt_rx_pd == gt_ctrl_pkg::rx_pd_default &&
            gt_tx_qpll_sel == gt_ctrl_pkg::tx_qpll_sel_default &&
            gt_rx_qpll_sel == gt_ctrl_pkg::rx_qpll_sel_default &&
            gt_rxlpmen == gt_ctrl_pkg::rx_lpm_en_default && !gt_rxcdrhold)
        else abort_run("outputs not at their reset values during or right after reset");

    a_rdy_follows_en: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        drp_en |-> ##2 drp_rdy) else abort_run("drp_rdy missing two cycles after drp_en");
    a_rdy_has_en: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        drp_rdy |-> $past(drp_en, 2)) else abort_run("drp_rdy without drp_en two cycles before");
    a_do_idle: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        !drp_rdy |-> drp_do == '0) else abort_run("drp_do not zero while drp_rdy is low");

    // Register pins settle at the third edge after the write
    a_tx_cfg_out: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        wr_tx_cfg |-> ##3 gt_tx_pd == $past(drp_di[0], 3) && gt_tx_qpll_sel == $past(drp_di[1], 3))
        else abort_run("gt_tx_pd or gt_tx_qpll_sel does not match the written value");
    a_rx_cfg_out: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        wr_rx_cfg |-> ##3 gt_rx_pd == $past(drp_di[0], 3) && gt_rx_qpll_sel == $past(drp_di[1], 3))
        else abort_run("gt_rx_pd or gt_rx_qpll_sel does not match the written value");
    a_cdrhold_out: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        wr_rx_cdr |-> ##3 gt_rxcdrhold == $past(drp_di[0], 3))
        else abort_run("gt_rxcdrhold does not follow its register");
    a_lpm_out: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        wr_rx_lpm |-> ##3 gt_rxlpmen == $past(drp_di[0], 3))
        else abort_run("gt_rxlpmen does not follow its register");

    a_tx_userrdy: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        $rose(gt_tx_userrdy) |-> !gt_tx_reset && $past(!gt_tx_reset))
        else abort_run("gt_tx_userrdy rose before gt_tx_reset fell");
    a_rx_userrdy: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        $rose(gt_rx_userrdy) |-> !gt_rx_reset && $past(!gt_rx_reset))
        else abort_run("gt_rx_userrdy rose before gt_rx_reset fell");

    // The CDR timeout is out of reach, so leaving the CDR wait needs lock
    a_rx_cdr_gate: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        $fell(gt_rx_prgdiv_reset) |-> gt_rxcdrlock)
        else abort_run("RX released its prgdiv reset without CDR lock");

    a_tx_restart_write: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        wr_tx_reset && drp_di[0]
        |-> ##[1:4] gt_tx_reset && gt_tx_prgdiv_reset && !tx_reset_done)
        else abort_run("TX did not restart after a write of its reset bit");
    a_tx_restart_lock: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        $fell(qpll0_lock) && !gt_tx_qpll_sel
        |-> ##[1:5] gt_tx_reset && gt_tx_prgdiv_reset && !tx_reset_done)
        else abort_run("TX did not restart after qpll0_lock dropped");
    a_rx_restart_lpm: assert property (@(posedge drp_clk) disable iff (gt_rx_reset_reg)
        wr_rx_lpm && drp_di[0] != gt_rxlpmen && rx_reset_done
        |-> ##[1:4] gt_rx_reset && gt_rx_prgdiv_reset && !rx_reset_done)
        else abort_run("RX did not restart after an LPM change");

    initial begin
        logic [15:0] val;
        logic [1:0] tx_cfg_m;
        logic [1:0] rx_cfg_m;
        logic tx_rst_m;
        logic rx_rst_m;
        logic cdr_m;
        logic lpm_m;
        lfsr_state = 32'h3bf0;
        gt_rx_reset_reg = 1'b1;
        drp_addr = '0;
        drp_di = '0;
        drp_en = 1'b0;
        drp_we = 1'b0;
        qpll0_lock = 1'b0;
        qpll1_lock = 1'b0;
        tx_usrclk_active = 1'b0;
        rx_usrclk_active = 1'b0;
        gt_tx_reset_done = 1'b0;
        gt_tx_prgdiv_reset_done = 1'b0;
        gt_rx_reset_done = 1'b0;
        gt_rx_prgdiv_reset_done = 1'b0;
        gt_rxcdrlock = 1'b0;
        repeat (8) @(posedge drp_clk);
        #1;
        gt_rx_reset_reg = 1'b0;

        read_reg("default tx_cfg", ctrl_addr(gt_ctrl_pkg::tx_cfg_addr),
            {14'b0, gt_ctrl_pkg::tx_qpll_sel_default, gt_ctrl_pkg::tx_pd_default});
        read_reg("default rx_cfg", ctrl_addr(gt_ctrl_pkg::rx_cfg_addr),
            {14'b0, gt_ctrl_pkg::rx_qpll_sel_default, gt_ctrl_pkg::rx_pd_default});
        read_reg("default rx_lpm", ctrl_addr(gt_ctrl_pkg::rx_lpm_addr),
            {15'b0, gt_ctrl_pkg::rx_lpm_en_default});

        // Random fields back to back with all status inputs low
        for (int round = 0; round < 3; round++) begin
            draw_bits(16, val);
            tx_cfg_m = val[1:0];
            write_reg(ctrl_addr(gt_ctrl_pkg::tx_cfg_addr), val);
            draw_bits(16, val);
            rx_cfg_m = val[1:0];
            write_reg(ctrl_addr(gt_ctrl_pkg::rx_cfg_addr), val);
            draw_bits(16, val);
            cdr_m = val[0];
            write_reg(ctrl_addr(gt_ctrl_pkg::rx_cdr_addr), val);
            draw_bits(16, val);
            lpm_m = val[0];
            write_reg(ctrl_addr(gt_ctrl_pkg::rx_lpm_addr), val);
            draw_bits(16, val);
            tx_rst_m = val[0];
            write_reg(ctrl_addr(gt_ctrl_pkg::tx_reset_addr), val);
            draw_bits(16, val);
            rx_rst_m = val[0];
            write_reg(ctrl_addr(gt_ctrl_pkg::rx_reset_addr), val);
            write_reg(17'h00001, 16'hffff);
            drain_requests();
            read_reg("tx_cfg", ctrl_addr(gt_ctrl_pkg::tx_cfg_addr), {14'b0, tx_cfg_m});
            read_reg("rx_cfg", ctrl_addr(gt_ctrl_pkg::rx_cfg_addr), {14'b0, rx_cfg_m});
            read_reg("rx_cdr", ctrl_addr(gt_ctrl_pkg::rx_cdr_addr), {15'b0, cdr_m});
            read_reg("rx_lpm", ctrl_addr(gt_ctrl_pkg::rx_lpm_addr), {15'b0, lpm_m});
            read_reg("tx_reset", ctrl_addr(gt_ctrl_pkg::tx_reset_addr), {15'b0, tx_rst_m});
            read_reg("rx_reset", ctrl_addr(gt_ctrl_pkg::rx_reset_addr), {15'b0, rx_rst_m});
            read_reg("outside space", 17'h00001, 16'h0000);
        end

        // TX bring-up on qpll0
        write_reg(ctrl_addr(gt_ctrl_pkg::tx_cfg_addr), 16'h0000);
        write_reg(ctrl_addr(gt_ctrl_pkg::tx_reset_addr), 16'h0000);
        drain_requests();
        @(posedge drp_clk);
        #1;
        qpll0_lock = 1'b1;
        tx_usrclk_active = 1'b1;
        gt_tx_reset_done = 1'b1;
        gt_tx_prgdiv_reset_done = 1'b1;
        wait_signal("tx_reset_done", 1'b1, 2000);
        wait_signal("gt_tx_userrdy", 1'b1, 4);
        read_reg("tx_reset status", ctrl_addr(gt_ctrl_pkg::tx_reset_addr), 16'h1b00);

        // Restart by reset bit and then by lock loss
        write_reg(ctrl_addr(gt_ctrl_pkg::tx_reset_addr), 16'h0001);
        drain_requests();
        wait_signal("tx_reset_done", 1'b0, 8);
        write_reg(ctrl_addr(gt_ctrl_pkg::tx_reset_addr), 16'h0000);
        drain_requests();
        wait_signal("tx_reset_done", 1'b1, 2000);
        @(posedge drp_clk);
        #1;
        qpll0_lock = 1'b0;
        wait_signal("tx_reset_done", 1'b0, 8);
        @(posedge drp_clk);
        #1;
        qpll0_lock = 1'b1;
        wait_signal("tx_reset_done", 1'b1, 2000);

        // RX on qpll1 only with a late CDR lock
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_cfg_addr), 16'h0002);
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_reset_addr), 16'h0000);
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_lpm_addr), 16'h0001);
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_cdr_addr), 16'h0000);
        drain_requests();
        @(posedge drp_clk);
        #1;
        qpll0_lock = 1'b0;
        qpll1_lock = 1'b1;
        rx_usrclk_active = 1'b1;
        gt_rx_reset_done = 1'b1;
        gt_rx_prgdiv_reset_done = 1'b1;
        repeat (300) @(posedge drp_clk);
        #1;
        gt_rxcdrlock = 1'b1;
        wait_signal("rx_reset_done", 1'b1, 2000);
        wait_signal("gt_rx_userrdy", 1'b1, 4);
        read_reg("rx_reset status", ctrl_addr(gt_ctrl_pkg::rx_reset_addr), 16'h1b00);
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_lpm_addr), 16'h0000);
        drain_requests();
        wait_signal("rx_reset_done", 1'b0, 8);
        wait_signal("rx_reset_done", 1'b1, 2000);
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_cdr_addr), 16'h0001);
        drain_requests();
        read_reg("rx_cdr hold and lock", ctrl_addr(gt_ctrl_pkg::rx_cdr_addr), 16'h0101);
        write_reg(ctrl_addr(gt_ctrl_pkg::rx_cdr_addr), 16'h0000);
        drain_requests();
        repeat (4) @(posedge drp_clk);

        $display("Verification passed");
        $finish;
    end

endmodule
